// ==== Makefile ====
TOP = dcache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== logic/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_consts.svh"

module cache_way (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic [`DC_TAG_W-1:0]   tag,
    input  logic [`DC_DATA_W-1:0]  write_data,
    input  logic [`DC_MASK_W-1:0]  write_mask,
    input  logic [`DC_DATA_W-1:0]  fill_data,
    input  dcache_pkg::way_cmd_e   cmd,
    output logic                   hit,
    output dcache_pkg::line_t      line
);

    dcache_pkg::line_t     entries [`DC_SETS];
    logic [`DC_DATA_W-1:0] merge_base;
    logic [`DC_DATA_W-1:0] merged;

    // ==============================
    // Lookup
    // ==============================

    assign line = entries[index];
    assign hit  = line.valid && (line.tag == tag);

    // Write hit keeps the stored bytes, write miss takes them from memory
    assign merge_base = (cmd == dcache_pkg::TOUCH_WRITE) ? line.data : fill_data;

    always_comb begin
        for (int b = 0; b < `DC_MASK_W; b++) begin
            merged[b*8 +: 8] = write_mask[b] ? write_data[b*8 +: 8] : merge_base[b*8 +: 8];
        end
    end

    // ==============================
    // Update
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                entries[s] <= '0;
            end
        end else begin
            case (cmd)
                dcache_pkg::TOUCH_WRITE: begin
                    entries[index].data  <= merged;
                    entries[index].dirty <= 1'b1;
                end
                dcache_pkg::FILL: begin
                    entries[index].valid <= 1'b1;
                    entries[index].dirty <= 1'b0;
                    entries[index].tag   <= tag;
                    entries[index].data  <= fill_data;
                end
                dcache_pkg::FILL_WRITE: begin
                    entries[index].valid <= 1'b1;
                    entries[index].dirty <= 1'b1; // Differs from memory at once
                    entries[index].tag   <= tag;
                    entries[index].data  <= merged;
                end
                dcache_pkg::CLEAN: begin
                    entries[index].dirty <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // Dirty implies valid after every update
    a_dirty_valid: assert property (@(posedge clk) disable iff (reset)
        (cmd != dcache_pkg::NONE) |=>
            !(entries[$past(index)].dirty && !entries[$past(index)].valid));

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_consts.svh"

module data_mem (
    input logic     clk,
    input logic     reset,
    mem_port_if.mem port
);

    logic [`DC_DATA_W-1:0] words [`DC_MEM_WORDS];

    // Fill path, same cycle
    assign port.fill_data = words[port.fill_addr];

    // Write-back lands on the edge after the flush is registered
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DC_MEM_WORDS; i++) begin
                words[i] <= '0;
            end
        end else if (port.wb_en) begin
            words[port.wb_addr] <= port.wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_consts.svh"

module dcache (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`DC_ADDR_W-1:0] address,
    input  logic                  read_enable,
    input  logic                  write_enable,
    input  logic [`DC_DATA_W-1:0] write_data,
    input  logic [`DC_MASK_W-1:0] write_mask,
    output logic                  hit,
    output logic [`DC_DATA_W-1:0] read_data,
    output logic [`DC_ADDR_W-1:0] flush_address,
    output logic [`DC_DATA_W-1:0] flush_data,
    output logic                  flush_done,
    mem_port_if.cache             mem
);

    logic [`DC_TAG_W-1:0]   tag;
    logic [`DC_INDEX_W-1:0] index;
    dcache_pkg::dc_op_e     op;
    dcache_pkg::way_cmd_e   way_cmd [2];
    dcache_pkg::line_t      way_line [2];
    logic [1:0]             way_hit;
    logic                   hit_way;
    logic                   lru [`DC_SETS]; // Way to evict next
    logic                   victim;
    dcache_pkg::line_t      victim_line;
    logic                   need_wb;

    assign tag   = address[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index = address[2 +: `DC_INDEX_W]; // Bits 1:0 select a byte, unused

    // Read wins over write
    always_comb begin
        if (read_enable)
            op = dcache_pkg::READ;
        else if (write_enable)
            op = dcache_pkg::WRITE;
        else
            op = dcache_pkg::IDLE;
    end

    // ==============================
    // Ways and victim choice
    // ==============================

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_way way_i (
            .clk        (clk),
            .reset      (reset),
            .index      (index),
            .tag        (tag),
            .write_data (write_data),
            .write_mask (write_mask),
            .fill_data  (mem.fill_data),
            .cmd        (way_cmd[w]),
            .hit        (way_hit[w]),
            .line       (way_line[w])
        );
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    always_comb begin
        if (!way_line[0].valid)
            victim = 1'b0;
        else if (!way_line[1].valid)
            victim = 1'b1;
        else
            victim = lru[index];
    end

    assign victim_line = way_line[victim];
    assign need_wb     = (op != dcache_pkg::IDLE) && !hit && victim_line.dirty;

    always_comb begin
        way_cmd[0] = dcache_pkg::NONE;
        way_cmd[1] = dcache_pkg::NONE;
        if (op != dcache_pkg::IDLE) begin
            if (hit) begin
                if (op == dcache_pkg::WRITE)
                    way_cmd[hit_way] = dcache_pkg::TOUCH_WRITE;
            end else if (need_wb) begin
                way_cmd[victim] = dcache_pkg::CLEAN; // Fill follows next cycle
            end else if (op == dcache_pkg::READ) begin
                way_cmd[victim] = dcache_pkg::FILL;
            end else begin
                way_cmd[victim] = dcache_pkg::FILL_WRITE;
            end
        end
    end

    // ==============================
    // LRU, read data, write-back
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                lru[s] <= 1'b0;
            end
            read_data     <= '0;
            flush_address <= '0;
            flush_data    <= '0;
            flush_done    <= 1'b1;
        end else begin
            read_data     <= '0;
            flush_address <= '0;
            flush_data    <= '0;
            flush_done    <= 1'b1;
            if (op != dcache_pkg::IDLE) begin
                if (hit) begin
                    lru[index] <= ~hit_way;
                    if (op == dcache_pkg::READ)
                        read_data <= way_line[hit_way].data;
                end else if (need_wb) begin
                    flush_address <= {victim_line.tag, index, 2'b00};
                    flush_data    <= victim_line.data;
                    flush_done    <= 1'b0;
                end else begin
                    lru[index] <= ~victim;
                end
            end
        end
    end

    assign mem.fill_addr = {tag, index};
    assign mem.wb_en     = ~flush_done;
    assign mem.wb_addr   = flush_address[`DC_ADDR_W-1:2];
    assign mem.wb_data   = flush_data;

    a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
        !(way_hit[0] && way_hit[1]));

    // Victim is clean after one write-back
    a_wb_single: assert property (@(posedge clk) disable iff (reset)
        mem.wb_en |=> !mem.wb_en);

    a_one_enable: assert property (@(posedge clk) disable iff (reset)
        !(read_enable && write_enable));

endmodule

`default_nettype wire

// ==== logic/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Address layout is tag, index, byte offset
`define DC_ADDR_W    10
`define DC_DATA_W    32
`define DC_MASK_W    4
`define DC_TAG_W     5
`define DC_INDEX_W   3
`define DC_SETS      8
`define DC_MEM_WORDS 256

`endif

// ==== logic/dcache_pkg.sv ====
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [`DC_TAG_W-1:0]  tag;
        logic [`DC_DATA_W-1:0] data;
    } line_t;

    // Access kind seen by the cache in one cycle
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } dc_op_e;

    typedef enum logic [2:0] {
        NONE,
        TOUCH_WRITE, // Write hit
        FILL,
        FILL_WRITE,  // Write miss, fill merged with write bytes
        CLEAN        // Victim written back
    } way_cmd_e;

endpackage

`default_nettype wire

// ==== logic/dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`DC_ADDR_W-1:0] address,
    input  logic                  read_enable,
    input  logic                  write_enable,
    input  logic [`DC_DATA_W-1:0] write_data,
    input  logic [`DC_MASK_W-1:0] write_mask,
    output logic                  hit,
    output logic [`DC_DATA_W-1:0] read_data,
    output logic                  flush_done,
    output logic [`DC_ADDR_W-1:0] flush_address,
    output logic [`DC_DATA_W-1:0] flush_data
);

    mem_port_if mem_port ();

    dcache dcache_i (
        .clk           (clk),
        .reset         (reset),
        .address       (address),
        .read_enable   (read_enable),
        .write_enable  (write_enable),
        .write_data    (write_data),
        .write_mask    (write_mask),
        .hit           (hit),
        .read_data     (read_data),
        .flush_address (flush_address),
        .flush_data    (flush_data),
        .flush_done    (flush_done),
        .mem           (mem_port)
    );

    // Backing store
    data_mem data_mem_i (
        .clk   (clk),
        .reset (reset),
        .port  (mem_port)
    );

endmodule

`default_nettype wire

// ==== logic/mem_port_if.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_consts.svh"

interface mem_port_if;

    logic [(`DC_TAG_W+`DC_INDEX_W)-1:0] fill_addr;
    logic [`DC_DATA_W-1:0]              fill_data; // Combinational from fill_addr
    logic                               wb_en;
    logic [(`DC_TAG_W+`DC_INDEX_W)-1:0] wb_addr;
    logic [`DC_DATA_W-1:0]              wb_data;

    modport cache (
        output fill_addr,
        input  fill_data,
        output wb_en,
        output wb_addr,
        output wb_data
    );

    modport mem (
        input  fill_addr,
        output fill_data,
        input  wb_en,
        input  wb_addr,
        input  wb_data
    );

endinterface

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/mem_port_if.sv
logic/cache_way.sv
logic/dcache.sv
logic/data_mem.sv
logic/dcache_top.sv
verif/dcache_tb.sv

// ==== verif/dcache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_tb;

    localparam int PERIOD         = 100;
    localparam int QUARTER        = PERIOD / 4;
    localparam int RESET_CYCLES   = 5;
    localparam int RANDOM_OPS     = 200;
    localparam int TEST_COUNT     = RANDOM_OPS + 30;
    localparam int TIMEOUT_CYCLES = TEST_COUNT * 6 + RESET_CYCLES;

    logic                  clk;
    logic                  reset;
    logic [`DC_ADDR_W-1:0] address;
    logic                  read_enable;
    logic                  write_enable;
    logic [`DC_DATA_W-1:0] write_data;
    logic [`DC_MASK_W-1:0] write_mask;
    logic                  hit;
    logic [`DC_DATA_W-1:0] read_data;
    logic                  flush_done;
    logic [`DC_ADDR_W-1:0] flush_address;
    logic [`DC_DATA_W-1:0] flush_data;

    logic [`DC_DATA_W-1:0] model [`DC_MEM_WORDS]; // Flat view of memory
    logic [`DC_ADDR_W-1:0] flush_seen_addr;
    integer                seed;
    int                    error_count;

    dcache_top dcache_top_i (
        .clk           (clk),
        .reset         (reset),
        .address       (address),
        .read_enable   (read_enable),
        .write_enable  (write_enable),
        .write_data    (write_data),
        .write_mask    (write_mask),
        .hit           (hit),
        .read_data     (read_data),
        .flush_done    (flush_done),
        .flush_address (flush_address),
        .flush_data    (flush_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ==============================
    // Reference model and checks
    // ==============================

    function automatic logic [`DC_DATA_W-1:0] model_word(input logic [`DC_ADDR_W-1:0] addr);
        return model[addr[`DC_ADDR_W-1:2]];
    endfunction

    function automatic void apply_write(input logic [`DC_ADDR_W-1:0] addr,
                                        input logic [`DC_DATA_W-1:0] data,
                                        input logic [`DC_MASK_W-1:0] mask);
        for (int b = 0; b < `DC_MASK_W; b++) begin
            if (mask[b])
                model[addr[`DC_ADDR_W-1:2]][b*8 +: 8] = data[b*8 +: 8];
        end
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    // read_data must carry the word only in the cycle after a read hit edge
    initial begin : read_checker
        logic                  read_hit;
        logic [`DC_DATA_W-1:0] expected;
        forever begin
            @(negedge clk);
            #(QUARTER);
            read_hit = !reset && read_enable && hit;
            expected = read_hit ? model_word(address) : '0;
            @(posedge clk);
            #(QUARTER);
            if (!reset)
                compare_value("read_data", read_data, expected);
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    // Called right after a falling edge, returns on the falling edge after the hit edge
    task automatic issue_request(input dcache_pkg::dc_op_e op, input logic [`DC_ADDR_W-1:0] addr,
                                 input logic [`DC_DATA_W-1:0] data,
                                 input logic [`DC_MASK_W-1:0] mask,
                                 output logic [`DC_DATA_W-1:0] rdata,
                                 output int wb_count, output int cycles);
        logic done;
        done         = 1'b0;
        wb_count     = 0;
        cycles       = 0;
        rdata        = '0;
        address      = addr;
        read_enable  = (op == dcache_pkg::READ);
        write_enable = (op == dcache_pkg::WRITE);
        write_data   = data;
        write_mask   = mask;
        while (!done && cycles < 4) begin
            #(QUARTER);
            done = hit;
            @(negedge clk);
            cycles++;
            if (!flush_done) begin
                wb_count++;
                flush_seen_addr = flush_address;
                compare_value("flush_data", flush_data, model_word(flush_address));
            end
        end
        if (done) begin
            rdata = read_data;
            if (op == dcache_pkg::WRITE)
                apply_write(addr, data, mask);
        end else begin
            $display("Request to address %h saw no hit within 4 cycles", addr);
            error_count++;
        end
        read_enable  = 1'b0;
        write_enable = 1'b0;
    endtask

    initial begin : stimulus
        logic [`DC_DATA_W-1:0] rd;
        logic [31:0]           rnd;
        dcache_pkg::dc_op_e    op;
        int                    wbs;
        int                    cyc;
        seed         = 32'hee3285ad;
        error_count  = 0;
        reset        = 1'b1;
        address      = '0;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        write_data   = '0;
        write_mask   = '0;
        for (int i = 0; i < `DC_MEM_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle state, then a cold read
        #(QUARTER);
        compare_value("hit", {31'b0, hit}, 32'h0);
        compare_value("flush_done", {31'b0, flush_done}, 32'h1);
        @(negedge clk);
        issue_request(dcache_pkg::READ, 10'h0a4, '0, '0, rd, wbs, cyc);
        compare_value("read_data", rd, 32'h0);

        // Two masked writes to one word
        issue_request(dcache_pkg::WRITE, 10'h048, 32'h11223344, 4'b0101, rd, wbs, cyc);
        issue_request(dcache_pkg::WRITE, 10'h048, 32'haabbccdd, 4'b1000, rd, wbs, cyc);
        issue_request(dcache_pkg::READ, 10'h048, '0, '0, rd, wbs, cyc);
        compare_value("read_data", rd, model_word(10'h048));

        // Set 5 with tags 1, 2, 3
        issue_request(dcache_pkg::WRITE, 10'h034, 32'hcafe0001, 4'hf, rd, wbs, cyc);
        issue_request(dcache_pkg::WRITE, 10'h054, 32'hbeef0002, 4'hf, rd, wbs, cyc);
        issue_request(dcache_pkg::READ, 10'h054, '0, '0, rd, wbs, cyc);
        compare_value("hit latency", cyc, 1);
        issue_request(dcache_pkg::READ, 10'h034, '0, '0, rd, wbs, cyc);
        compare_value("hit latency", cyc, 1);
        issue_request(dcache_pkg::READ, 10'h074, '0, '0, rd, wbs, cyc);
        compare_value("flush_done pulses", wbs, 1);
        compare_value("flush_address", {22'b0, flush_seen_addr}, 32'h054);

        // Evicted dirty word comes back from memory and evicts tag 1
        issue_request(dcache_pkg::READ, 10'h054, '0, '0, rd, wbs, cyc);
        compare_value("flush_done pulses", wbs, 1);
        compare_value("flush_address", {22'b0, flush_seen_addr}, 32'h034);
        compare_value("read_data", rd, model_word(10'h054));

        // Random traffic
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd = $random(seed);
            op  = rnd[31] ? dcache_pkg::READ : dcache_pkg::WRITE;
            issue_request(op, rnd[9:0], $random(seed), rnd[13:10], rd, wbs, cyc);
        end

        @(negedge clk);
        $display("Summary: %0d errors", error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * PERIOD);
        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Summary: %0d errors", error_count);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
